/* common/stb_pkg.sv */
// shared widths, the buffered store record and FSM state types; imported by every store buffer file
package stb_pkg;

    // byte address width seen by the LSU and the memory
    localparam int ADDR_WIDTH = 32;

    // data word width
    localparam int DATA_WIDTH = 32;

    // one enable per byte lane of a word
    localparam int SEL_WIDTH  = DATA_WIDTH / 8;

    // one buffered store
    // 32 + 32 + 4 = 68 bits, addr in the top bits
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic [SEL_WIDTH-1:0]  sel_byte;
    } stb_entry_t;

    // lsu side controller
    // idle waits for a store, ack is the single acknowledge cycle
    typedef enum logic {
        LSU_IDLE,
        LSU_ACK
    } lsu_state_e;

    // drain side controller
    // req is the first request cycle, wait_ack holds it until the memory answers
    typedef enum logic [1:0] {
        CACHE_IDLE,
        CACHE_REQ,
        CACHE_WAIT_ACK
    } cache_state_e;

endpackage

/* common/dcache_bus_if.sv */
// request/acknowledge bus from the store buffer to the data memory; master is the buffer, slave the memory
interface dcache_bus_if
    import stb_pkg::*;
();

    // request fields, held stable by the master until ack
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic [SEL_WIDTH-1:0]  sel_byte;
    logic                  w_en;
    logic                  req;

    // response, ack is a one cycle pulse
    // rdata only valid while ack is high
    logic                  ack;
    logic [DATA_WIDTH-1:0] rdata;

    // store buffer side
    modport master (
        output addr,
        output wdata,
        output sel_byte,
        output w_en,
        output req,
        input  ack,
        input  rdata
    );

    // memory side
    modport slave (
        input  addr,
        input  wdata,
        input  sel_byte,
        input  w_en,
        input  req,
        output ack,
        output rdata
    );

endinterface

/* store_buffer/store_buffer_datapath.sv */
// circular FIFO holding pending stores; written by the lsu controller, drained by the cache controller
module store_buffer_datapath
    import stb_pkg::*;
#(
    // number of entries as a power of two
    parameter int STB_DEPTH = 4
) (
    input  logic       clk,
    input  logic       reset_i,

    // push from lsu_stb_controller
    input  logic       wr_en_i,
    input  stb_entry_t wr_entry_i,

    // pop from stb_cache_controller
    input  logic       rd_en_i,

    // oldest entry always presented
    output stb_entry_t head_o,

    // occupancy flags to both controllers
    output logic       full_o,
    output logic       empty_o
);

    localparam int PTR_W = $clog2(STB_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // entry storage
    stb_entry_t       entries_q [STB_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    // pointers wrap on their own as the depth is a power of two
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_en_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // push and pop together keep the count
            if (wr_en_i && !rd_en_i) begin
                count_q <= count_q + 1'b1;
            end else if (rd_en_i && !wr_en_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // payload write
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            entries_q[wr_ptr_q] <= wr_entry_i;
        end
    end

    assign head_o  = entries_q[rd_ptr_q];
    assign full_o  = (count_q == CNT_W'(STB_DEPTH));
    assign empty_o = (count_q == '0);

    // lsu controller must hold off while full
    a_no_push_when_full: assert property (@(posedge clk) disable iff (reset_i)
        wr_en_i |-> !full_o);

    // cache controller only pops a valid head
    a_no_pop_when_empty: assert property (@(posedge clk) disable iff (reset_i)
        rd_en_i |-> !empty_o);

endmodule

/* store_buffer/lsu_stb_controller.sv */
// accepts lsu stores into the store buffer FIFO and returns the store acknowledge one cycle later
module lsu_stb_controller
    import stb_pkg::*;
(
    input  logic clk,
    input  logic reset_i,

    // level request from the lsu
    input  logic lsu_req_i,
    input  logic lsu_w_en_i,

    // FIFO has no room
    input  logic full_i,

    // push one entry into the datapath
    output logic wr_en_o,

    // store acknowledge back to the lsu
    output logic stb_ack_o
);

    lsu_state_e state_q;
    lsu_state_e state_d;
    logic       store_req;

    // stores only since loads take the bypass path
    assign store_req = lsu_req_i && lsu_w_en_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= LSU_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        wr_en_o = 1'b0;
        case (state_q)
            LSU_IDLE: begin
                // request stays held while full
                if (store_req && !full_i) begin
                    wr_en_o = 1'b1;
                    state_d = LSU_ACK;
                end
            end
            LSU_ACK: begin
                // request still up this cycle
                // no write here so it is not stored twice
                state_d = LSU_IDLE;
            end
            default: begin
                state_d = LSU_IDLE;
            end
        endcase
    end

    // ack is the cycle after the write edge
    assign stb_ack_o = (state_q == LSU_ACK);

    // lsu holds the store through its ack cycle
    // a dropped request would let the bypass mux swallow this ack
    a_store_held_at_ack: assert property (@(posedge clk) disable iff (reset_i)
        stb_ack_o |-> store_req);

endmodule

/* store_buffer/stb_cache_controller.sv */
// drains the store buffer FIFO head to the data memory, one request/ack exchange per entry
module stb_cache_controller
    import stb_pkg::*;
(
    input  logic clk,
    input  logic reset_i,

    // FIFO has nothing to drain
    input  logic empty_i,

    // memory acknowledge for the current request
    input  logic bus_ack_i,

    // pop the head once written
    output logic rd_en_o,

    // drain request towards the bus mux
    output logic req_o,
    output logic w_en_o
);

    cache_state_e state_q;
    cache_state_e state_d;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= CACHE_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        rd_en_o = 1'b0;
        case (state_q)
            CACHE_IDLE: begin
                // req goes up one cycle after the FIFO turns non-empty
                if (!empty_i) begin
                    state_d = CACHE_REQ;
                end
            end
            CACHE_REQ: begin
                // memory samples req at the end of this cycle
                // so its ack cannot land here
                state_d = CACHE_WAIT_ACK;
            end
            CACHE_WAIT_ACK: begin
                if (bus_ack_i) begin
                    // write done so drop the head
                    rd_en_o = 1'b1;
                    state_d = CACHE_IDLE;
                end
            end
            default: begin
                state_d = CACHE_IDLE;
            end
        endcase
    end

    // req and w_en held through the whole exchange
    // idle cycle after ack drops req as the bus requires
    assign req_o  = (state_q != CACHE_IDLE);
    assign w_en_o = req_o;

    // an ack in the first request cycle would be stale or too early
    a_no_ack_in_req: assert property (@(posedge clk) disable iff (reset_i)
        (state_q == CACHE_REQ) |-> !bus_ack_i);

endmodule

/* store_buffer/store_buffer_top.sv */
// store buffer: queues lsu stores, drains them to memory and lets loads bypass once the buffer is empty
module store_buffer_top
    import stb_pkg::*;
#(
    parameter int STB_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  reset_i,

    // lsu request
    input  logic                  lsu_req_i,
    input  logic                  lsu_w_en_i,
    input  logic [ADDR_WIDTH-1:0] lsu_addr_i,
    input  logic [DATA_WIDTH-1:0] lsu_wdata_i,
    input  logic [SEL_WIDTH-1:0]  lsu_sel_byte_i,

    // lsu response
    output logic                  lsu_ack_o,
    output logic [DATA_WIDTH-1:0] lsu_rdata_o,

    // all stores written to memory
    output logic                  stb_empty_o,

    // memory side
    dcache_bus_if.master          bus
);

    stb_entry_t lsu_entry;
    stb_entry_t head;

    logic       wr_en;
    logic       rd_en;
    logic       stb_full;
    logic       stb_empty;
    logic       stb_ack;
    logic       drain_req;
    logic       drain_w_en;
    logic       bypass;

    // lsu fields packed as a FIFO entry
    assign lsu_entry = '{addr: lsu_addr_i, wdata: lsu_wdata_i, sel_byte: lsu_sel_byte_i};

    // no store on the lsu port and nothing pending
    // a load held during the drain goes out once empty rises
    assign bypass = !(lsu_req_i && lsu_w_en_i) && stb_empty;

    always_comb begin
        if (bypass) begin
            // lsu talks to memory directly
            bus.addr     = lsu_entry.addr;
            bus.wdata    = lsu_entry.wdata;
            bus.sel_byte = lsu_entry.sel_byte;
            bus.req      = lsu_req_i;
            bus.w_en     = lsu_w_en_i;
            lsu_ack_o    = bus.ack;
            lsu_rdata_o  = bus.rdata;
        end else begin
            // drain of the head, lsu only sees store acks
            bus.addr     = head.addr;
            bus.wdata    = head.wdata;
            bus.sel_byte = head.sel_byte;
            bus.req      = drain_req;
            bus.w_en     = drain_w_en;
            lsu_ack_o    = stb_ack;
            lsu_rdata_o  = '0;
        end
    end

    assign stb_empty_o = stb_empty;

    store_buffer_datapath #(
        .STB_DEPTH (STB_DEPTH)
    ) u_datapath (
        .clk        (clk),
        .reset_i    (reset_i),
        .wr_en_i    (wr_en),
        .wr_entry_i (lsu_entry),
        .rd_en_i    (rd_en),
        .head_o     (head),
        .full_o     (stb_full),
        .empty_o    (stb_empty)
    );

    lsu_stb_controller u_lsu_ctrl (
        .clk        (clk),
        .reset_i    (reset_i),
        .lsu_req_i  (lsu_req_i),
        .lsu_w_en_i (lsu_w_en_i),
        .full_i     (stb_full),
        .wr_en_o    (wr_en),
        .stb_ack_o  (stb_ack)
    );

    // ack routed to the drain side always, it ignores it outside wait_ack
    stb_cache_controller u_cache_ctrl (
        .clk        (clk),
        .reset_i    (reset_i),
        .empty_i    (stb_empty),
        .bus_ack_i  (bus.ack),
        .rd_en_o    (rd_en),
        .req_o      (drain_req),
        .w_en_o     (drain_w_en)
    );

endmodule

/* src/data_mem.sv */
// word-addressed data memory with byte-enable writes and a fixed ack latency; stands in for the dcache
module data_mem
    import stb_pkg::*;
#(
    parameter int MEM_WORDS   = 256,
    // cycles from first sampled req to ack, at least 1
    parameter int MEM_LATENCY = 2
) (
    input  logic         clk,
    input  logic         reset_i,
    dcache_bus_if.slave  bus
);

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    logic [DATA_WIDTH-1:0] mem_q [MEM_WORDS];
    logic [CNT_W-1:0]      lat_cnt_q;
    logic                  ack_q;
    logic [DATA_WIDTH-1:0] rdata_q;
    logic [IDX_W-1:0]      word_idx;
    logic                  start;
    logic                  done;

    // byte address to word index
    assign word_idx = bus.addr[IDX_W+1:2];

    // new request only when idle and not in the ack cycle of the last one
    assign start = bus.req && (lat_cnt_q == '0) && !ack_q;
    assign done  = (start || lat_cnt_q != '0) && (lat_cnt_q == CNT_W'(MEM_LATENCY - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            lat_cnt_q <= '0;
            ack_q     <= 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            ack_q <= done;
            if (done) begin
                lat_cnt_q <= '0;
                // enabled byte lanes only
                if (bus.w_en) begin
                    for (int b = 0; b < SEL_WIDTH; b++) begin
                        if (bus.sel_byte[b]) begin
                            mem_q[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                        end
                    end
                end
            end else if (start || lat_cnt_q != '0) begin
                lat_cnt_q <= lat_cnt_q + 1'b1;
            end
        end
    end

    // read word captured with the ack
    always_ff @(posedge clk) begin
        if (done) begin
            rdata_q <= mem_q[word_idx];
        end
    end

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;

    // upper address bits would alias onto low words
    a_addr_in_range: assert property (@(posedge clk) disable iff (reset_i)
        bus.req |-> (bus.addr[ADDR_WIDTH-1:2] < MEM_WORDS));

endmodule

/* src/stb_subsystem_top.sv */
// top level joining the store buffer and the data memory; lsu side exposed as plain ports
module stb_subsystem_top
    import stb_pkg::*;
#(
    parameter int STB_DEPTH   = 4,
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 2
) (
    input  logic                  clk,
    input  logic                  reset_i,

    // lsu request
    input  logic                  lsu_req_i,
    input  logic                  lsu_w_en_i,
    input  logic [ADDR_WIDTH-1:0] lsu_addr_i,
    input  logic [DATA_WIDTH-1:0] lsu_wdata_i,
    input  logic [SEL_WIDTH-1:0]  lsu_sel_byte_i,

    // lsu response
    output logic                  lsu_ack_o,
    output logic [DATA_WIDTH-1:0] lsu_rdata_o,

    // no stores pending
    output logic                  stb_empty_o
);

    // buffer to memory
    dcache_bus_if dbus ();

    store_buffer_top #(
        .STB_DEPTH (STB_DEPTH)
    ) u_store_buffer (
        .clk            (clk),
        .reset_i        (reset_i),
        .lsu_req_i      (lsu_req_i),
        .lsu_w_en_i     (lsu_w_en_i),
        .lsu_addr_i     (lsu_addr_i),
        .lsu_wdata_i    (lsu_wdata_i),
        .lsu_sel_byte_i (lsu_sel_byte_i),
        .lsu_ack_o      (lsu_ack_o),
        .lsu_rdata_o    (lsu_rdata_o),
        .stb_empty_o    (stb_empty_o),
        .bus            (dbus.master)
    );

    data_mem #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_data_mem (
        .clk     (clk),
        .reset_i (reset_i),
        .bus     (dbus.slave)
    );

endmodule

/* sim/tb_stb_subsystem.sv */
// directed testbench for the store buffer subsystem; run through sim.f, compares loads with a byte model
module tb_stb_subsystem;

    localparam int STB_DEPTH  = 4;
    localparam int MEM_BYTES  = 1024;
    // longest single wait, in cycles
    localparam int WAIT_LIMIT = 200;

    logic        clk;
    logic        reset;
    logic        lsu_req;
    logic        lsu_w_en;
    logic [31:0] lsu_addr;
    logic [31:0] lsu_wdata;
    logic [3:0]  lsu_sel;
    logic        lsu_ack;
    logic [31:0] lsu_rdata;
    logic        stb_empty;

    // byte model of the data memory, lane b of a word at byte address 4*word + b
    logic [7:0]  ref_bytes [MEM_BYTES];

    int          errors    = 0;
    int          checks    = 0;
    int          ack_total = 0;
    int          test_base = 0;
    integer      seed      = 19;
    string       cur_test;

    stb_subsystem_top DUT (
        .clk            (clk),
        .reset_i        (reset),
        .lsu_req_i      (lsu_req),
        .lsu_w_en_i     (lsu_w_en),
        .lsu_addr_i     (lsu_addr),
        .lsu_wdata_i    (lsu_wdata),
        .lsu_sel_byte_i (lsu_sel),
        .lsu_ack_o      (lsu_ack),
        .lsu_rdata_o    (lsu_rdata),
        .stb_empty_o    (stb_empty)
    );

    always #10 clk = ~clk;

    // every ack cycle the lsu sees, sampled mid cycle
    always @(negedge clk) begin
        if (!reset && lsu_ack) begin
            ack_total++;
        end
    end

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        int base;
        base = int'(addr[9:2]) * 4;
        return {ref_bytes[base+3], ref_bytes[base+2], ref_bytes[base+1], ref_bytes[base]};
    endfunction

    // only the selected byte lanes change
    function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                        input logic [3:0] sel);
        int base;
        base = int'(addr[9:2]) * 4;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                ref_bytes[base+b] = data[8*b +: 8];
            end
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %s: %s expected %h actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %s: %s expected %b actual %b", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // waits for one ack pulse, grabs rdata and the empty flag in that cycle
    task automatic wait_for_ack(input string what, output logic [31:0] data,
                                output logic empty_at_ack);
        int   cycles;
        logic seen;
        cycles       = 0;
        seen         = 1'b0;
        data         = '0;
        empty_at_ack = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (lsu_ack) begin
                seen         = 1'b1;
                data         = lsu_rdata;
                empty_at_ack = stb_empty;
            end
        end
        if (!seen) begin
            $display("%s: the %s got no ack within %0d cycles", cur_test, what, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic wait_for_empty();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!stb_empty && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!stb_empty) begin
            $display("%s: store buffer did not drain within %0d cycles", cur_test, WAIT_LIMIT);
            errors++;
        end
    endtask

    // request stays up until the next op changes it
    task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] sel);
        logic [31:0] rdata;
        logic        empty_flag;
        @(posedge clk);
        lsu_req   <= 1'b1;
        lsu_w_en  <= 1'b1;
        lsu_addr  <= addr;
        lsu_wdata <= data;
        lsu_sel   <= sel;
        wait_for_ack("store", rdata, empty_flag);
        model_write(addr, data, sel);
        // store acks carry no read data
        check_value("store rdata", 32'h0, rdata);
    endtask

    task automatic load_word(input logic [31:0] addr, output logic [31:0] data,
                             output logic empty_at_ack);
        @(posedge clk);
        lsu_req   <= 1'b1;
        lsu_w_en  <= 1'b0;
        lsu_addr  <= addr;
        lsu_wdata <= '0;
        lsu_sel   <= '0;
        wait_for_ack("load", data, empty_at_ack);
    endtask

    task automatic release_lsu();
        @(posedge clk);
        lsu_req  <= 1'b0;
        lsu_w_en <= 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_base = errors;
    endtask

    task automatic end_test();
        $display("%s: done, %0d error(s)", cur_test, errors - test_base);
    endtask

    task automatic test_reset_load();
        logic [31:0] data;
        logic        empty_flag;
        begin_test("reset_load");
        @(negedge clk);
        check_flag("stb_empty_o after reset", 1'b1, stb_empty);
        load_word(32'h40, data, empty_flag);
        check_value("load after reset", 32'h0, data);
        // last word of the memory
        load_word(32'h3fc, data, empty_flag);
        check_value("load of last word", 32'h0, data);
        release_lsu();
        end_test();
    endtask

    task automatic test_store_load();
        logic [31:0] data;
        logic        empty_flag;
        begin_test("store_load");
        store_word(32'h10, 32'hdead_beef, 4'hf);
        check_flag("stb_empty_o with a store pending", 1'b0, stb_empty);
        load_word(32'h10, data, empty_flag);
        check_value("load of stored word", model_read(32'h10), data);
        // bypass only once drained
        check_flag("stb_empty_o at load ack", 1'b1, empty_flag);
        release_lsu();
        end_test();
    endtask

    task automatic test_partial_merge();
        logic [31:0] data;
        logic        empty_flag;
        begin_test("partial_merge");
        store_word(32'h24, 32'haaaa_aaaa, 4'b0011);
        store_word(32'h24, 32'h5555_5555, 4'b1100);
        store_word(32'h24, 32'h1234_5678, 4'b0100);
        load_word(32'h24, data, empty_flag);
        check_value("merged word", model_read(32'h24), data);
        release_lsu();
        end_test();
    endtask

    // enough stores to fill the FIFO and stall on full
    task automatic test_overflow();
        int          n;
        int          acks_before;
        logic [31:0] data;
        logic        empty_flag;
        begin_test("overflow");
        n           = 3 * STB_DEPTH;
        acks_before = ack_total;
        for (int i = 0; i < n; i++) begin
            store_word(32'h80 + 32'(4 * i), {8'(i), 8'ha5, 8'(i + 1), 8'h5a}, 4'hf);
        end
        release_lsu();
        wait_for_empty();
        check_value("ack count", 32'(n), 32'(ack_total - acks_before));
        for (int i = 0; i < n; i++) begin
            load_word(32'h80 + 32'(4 * i), data, empty_flag);
            check_value("load after drain", model_read(32'h80 + 32'(4 * i)), data);
        end
        release_lsu();
        end_test();
    endtask

    task automatic test_ordering();
        logic [31:0] data;
        logic        empty_flag;
        begin_test("ordering");
        store_word(32'h100, 32'h0bad_f00d, 4'hf);
        store_word(32'h104, 32'h1234_5678, 4'hf);
        store_word(32'h100, 32'hee00_0000, 4'b1000);
        // load goes out on the next edge, stores still queued
        check_flag("stores pending at load issue", 1'b0, stb_empty);
        load_word(32'h100, data, empty_flag);
        check_value("load behind pending stores", model_read(32'h100), data);
        check_flag("stb_empty_o at load ack", 1'b1, empty_flag);
        load_word(32'h104, data, empty_flag);
        check_value("load of second word", model_read(32'h104), data);
        release_lsu();
        end_test();
    endtask

    task automatic test_random();
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [31:0] data;
        logic        empty_flag;
        begin_test("random");
        for (int i = 0; i < 60; i++) begin
            rnd  = $random(seed);
            // 16 words starting at 0x200
            addr = 32'h200 + {26'd0, rnd[8:5], 2'b00};
            if (rnd[4]) begin
                data = $random(seed);
                store_word(addr, data, (rnd[3:0] == 4'h0) ? 4'hf : rnd[3:0]);
            end else begin
                load_word(addr, data, empty_flag);
                check_value("random load", model_read(addr), data);
            end
        end
        release_lsu();
        wait_for_empty();
        end_test();
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        lsu_req   = 1'b0;
        lsu_w_en  = 1'b0;
        lsu_addr  = '0;
        lsu_wdata = '0;
        lsu_sel   = '0;
        // memory comes out of reset cleared
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_bytes[i] = 8'h00;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        test_reset_load();
        test_store_load();
        test_partial_merge();
        test_overflow();
        test_ordering();
        test_random();

        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* sim.f */
common/stb_pkg.sv
common/dcache_bus_if.sv
store_buffer/store_buffer_datapath.sv
store_buffer/lsu_stb_controller.sv
store_buffer/stb_cache_controller.sv
store_buffer/store_buffer_top.sv
src/data_mem.sv
src/stb_subsystem_top.sv
sim/tb_stb_subsystem.sv

/* Makefile */
# Verilator lint and simulation of the store buffer subsystem
VERILATOR ?= verilator
TOP       ?= tb_stb_subsystem
RTL_TOP   ?= stb_subsystem_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not report success"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
